//--- hdl/vend_cfg.svh
`ifndef VEND_CFG_SVH
`define VEND_CFG_SVH

// the front panel has one bit per coin and one bit per item.
`define VEND_COIN_BITS 4
`define VEND_ITEM_BITS 5

// every money value is counted in 5-cent units.
`define VEND_UNIT_BITS 5

// coins are refused once the credit reaches 60 cents.
`define VEND_CREDIT_CAP 12

// coin values in units are listed by coin bit 0 to 3.
`define VEND_COIN_5  1
`define VEND_COIN_10 2
`define VEND_COIN_20 4
`define VEND_COIN_50 10

// item prices in units are listed by item bit 0 to 4.
`define VEND_PRICE_PACKET  6
`define VEND_PRICE_CAN     8
`define VEND_PRICE_BOTTLE  5
`define VEND_PRICE_WRAPPER 3
`define VEND_PRICE_TUB     12

`endif

//--- hdl/vend_money_pkg.sv
`default_nettype none

`include "vend_cfg.svh"

package vend_money_pkg;

        // the largest value is 21 units, 55 cents plus a 50-cent coin.
        typedef logic [`VEND_UNIT_BITS-1:0] units_t;

        typedef units_t credit_t; // inserted credit.

        typedef units_t price_t; // price of one item.

        typedef units_t change_t; // change returned after a sale.

endpackage

`default_nettype wire

//--- hdl/vend_panel_pkg.sv
`default_nettype none

`include "vend_cfg.svh"

package vend_panel_pkg;

        // bit 0 is the 5-cent coin and bit 3 the 50-cent coin.
        typedef logic [`VEND_COIN_BITS-1:0] coin_vec_t;

        // packet, can, bottle, wrapper and tub from bit 0 up.
        typedef logic [`VEND_ITEM_BITS-1:0] item_vec_t;

endpackage

`default_nettype wire

//--- hdl/vend_ifs.sv
`timescale 1ns/10ps
`default_nettype none

interface panel_if;
        import vend_money_pkg::*;

        logic   coin_stb;
        units_t coin_units; // valid only while coin_stb is high.
        logic   item_stb;
        price_t item_price; // valid only while item_stb is high.

        modport source (
                output coin_stb,
                output coin_units,
                output item_stb,
                output item_price
        );

        modport sink (
                input coin_stb,
                input coin_units,
                input item_stb,
                input item_price
        );
endinterface

interface sale_if;
        import vend_money_pkg::*;

        logic    sale_stb;
        logic    sale_ok;
        credit_t sale_credit; // credit before the sale is applied.
        price_t  sale_price;

        modport issuer (
                output sale_stb,
                output sale_ok,
                output sale_credit,
                output sale_price
        );

        modport dispenser (
                input sale_stb,
                input sale_ok,
                input sale_credit,
                input sale_price
        );
endinterface

`default_nettype wire

//--- hdl/panel_decoder.sv
`timescale 1ns/10ps
`default_nettype none

`include "vend_cfg.svh"

module panel_decoder (
        input wire vend_panel_pkg::coin_vec_t coins,
        input wire vend_panel_pkg::item_vec_t items,
        panel_if.source                       panel
);
        import vend_money_pkg::*;
        import vend_panel_pkg::*;

        logic   coin_any;
        logic   item_any;
        units_t coin_value;
        price_t item_cost;

        assign coin_any = |coins;
        assign item_any = |items;

        // the lowest coin bit wins when several are high.
        always_comb begin
                if (coins[0]) begin
                        coin_value = units_t'(`VEND_COIN_5);
                end else if (coins[1]) begin
                        coin_value = units_t'(`VEND_COIN_10);
                end else if (coins[2]) begin
                        coin_value = units_t'(`VEND_COIN_20);
                end else if (coins[3]) begin
                        coin_value = units_t'(`VEND_COIN_50);
                end else begin
                        coin_value = '0;
                end
        end

        // Priority runs wrapper, bottle, packet, can, tub.
        always_comb begin
                if (items[3]) begin
                        item_cost = price_t'(`VEND_PRICE_WRAPPER);
                end else if (items[2]) begin
                        item_cost = price_t'(`VEND_PRICE_BOTTLE);
                end else if (items[0]) begin
                        item_cost = price_t'(`VEND_PRICE_PACKET);
                end else if (items[1]) begin
                        item_cost = price_t'(`VEND_PRICE_CAN);
                end else if (items[4]) begin
                        item_cost = price_t'(`VEND_PRICE_TUB);
                end else begin
                        item_cost = '0;
                end
        end

        assign panel.coin_stb   = coin_any && !item_any; // a selection overrides the coin.
        assign panel.coin_units = coin_value;
        assign panel.item_stb   = item_any;
        assign panel.item_price = item_cost;

endmodule

`default_nettype wire

//--- hdl/credit_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "vend_cfg.svh"

module credit_unit (
        input wire                      clk,
        input wire                      rst,
        panel_if.sink                   panel,
        sale_if.issuer                  sale,
        output vend_money_pkg::credit_t credit
);
        import vend_money_pkg::*;

        credit_t credit_q;
        credit_t credit_d;
        logic    below_cap;
        logic    coin_taken;
        logic    covers_price;

        assign below_cap    = credit_q < credit_t'(`VEND_CREDIT_CAP);
        assign coin_taken   = panel.coin_stb && below_cap; // coins at the cap are ignored.
        assign covers_price = credit_q >= panel.item_price;

        // The credit is at most 11 units when a coin is added, so the sum stays in range.
        always_comb begin
                credit_d = credit_q;
                if (panel.item_stb) begin
                        if (covers_price) begin
                                credit_d = '0; // an accepted sale uses up the credit.
                        end
                end else if (coin_taken) begin
                        credit_d = credit_q + panel.coin_units;
                end
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        credit_q <= '0;
                end else begin
                        credit_q <= credit_d;
                end
        end

        // the sale record is formed in the cycle of the selection.
        assign sale.sale_stb    = panel.item_stb;
        assign sale.sale_ok     = covers_price;
        assign sale.sale_credit = credit_q;
        assign sale.sale_price  = panel.item_price;

        assign credit = credit_q;

endmodule

`default_nettype wire

//--- hdl/change_dispenser.sv
`timescale 1ns/10ps
`default_nettype none

module change_dispenser (
        input wire                      clk,
        input wire                      rst,
        sale_if.dispenser               sale,
        output vend_money_pkg::change_t change,
        output logic                    vend_stb,
        output logic                    need_more_stb
);
        import vend_money_pkg::*;

        change_t change_amount;

        // only used on an accepted sale, where the credit is at least the price.
        assign change_amount = change_t'(sale.sale_credit - sale.sale_price);

        always_ff @(posedge clk) begin
                if (rst) begin
                        vend_stb      <= 1'b0;
                        need_more_stb <= 1'b0;
                end else begin
                        vend_stb      <= sale.sale_stb && sale.sale_ok;
                        need_more_stb <= sale.sale_stb && !sale.sale_ok;
                end
        end

        // change holds its value between sales.
        always_ff @(posedge clk) begin
                if (rst) begin
                        change <= '0;
                end else if (sale.sale_stb) begin
                        if (sale.sale_ok) begin
                                change <= change_amount;
                        end else begin
                                change <= '0; // nothing is returned on a refused sale.
                        end
                end
        end

endmodule

`default_nettype wire

//--- hdl/vend_machine.sv
`timescale 1ns/10ps
`default_nettype none

`include "vend_cfg.svh"

module vend_machine (
        input wire                        clk,
        input wire                        rst,
        input wire [`VEND_COIN_BITS-1:0]  coins,
        input wire [`VEND_ITEM_BITS-1:0]  items,
        output logic [`VEND_UNIT_BITS-1:0] credit,
        output logic [`VEND_UNIT_BITS-1:0] change,
        output logic                      vend_stb,
        output logic                      need_more_stb
);

        panel_if panel ();
        sale_if  sale ();

        panel_decoder u_panel_decoder (
                .coins (coins),
                .items (items),
                .panel (panel.source)
        );

        credit_unit u_credit_unit (
                .clk    (clk),
                .rst    (rst),
                .panel  (panel.sink),
                .sale   (sale.issuer),
                .credit (credit)
        );

        change_dispenser u_change_dispenser (
                .clk           (clk),
                .rst           (rst),
                .sale          (sale.dispenser),
                .change        (change),
                .vend_stb      (vend_stb),
                .need_more_stb (need_more_stb)
        );

endmodule

`default_nettype wire

//--- sim/vend_checker.sv
`timescale 1ns/10ps
`default_nettype none

`include "vend_cfg.svh"

module vend_checker (
        input wire                            clk,
        input wire                            rst,
        input wire vend_panel_pkg::coin_vec_t coins,
        input wire vend_panel_pkg::item_vec_t items,
        input wire [8*24-1:0]                 label,
        input wire vend_money_pkg::credit_t   credit,
        input wire vend_money_pkg::change_t   change,
        input wire                            vend_stb,
        input wire                            need_more_stb,
        output integer                        test_count,
        output integer                        error_count
);
        import vend_money_pkg::*;
        import vend_panel_pkg::*;

        credit_t         model_credit;
        change_t         exp_change;
        price_t          price_now;
        logic            exp_vend;
        logic            exp_need;
        logic            pend_reset;
        logic            pend_event;
        logic            reset_done;
        logic            checking;
        logic [8*24-1:0] ev_label;
        integer          errors_before;

        function automatic units_t coin_value(input coin_vec_t c);
                units_t v;
                v = '0;
                if (c[3]) v = `VEND_COIN_50;
                if (c[2]) v = `VEND_COIN_20;
                if (c[1]) v = `VEND_COIN_10;
                if (c[0]) v = `VEND_COIN_5; // the lowest coin overwrites the others.
                return v;
        endfunction

        function automatic price_t price_of(input item_vec_t i);
                price_t p;
                p = '0;
                if (i[4]) p = `VEND_PRICE_TUB;
                if (i[1]) p = `VEND_PRICE_CAN;
                if (i[0]) p = `VEND_PRICE_PACKET;
                if (i[2]) p = `VEND_PRICE_BOTTLE;
                if (i[3]) p = `VEND_PRICE_WRAPPER; // wrapper comes first in priority.
                return p;
        endfunction

        task automatic compare_field(input string name, input logic [7:0] got,
                                     input logic [7:0] exp);
                if (got !== exp) begin
                        $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
                        error_count = error_count + 1;
                end
        endtask

        task automatic compare_all;
                compare_field("credit", credit, model_credit);
                compare_field("change", change, exp_change);
                compare_field("vend_stb", vend_stb, exp_vend);
                compare_field("need_more_stb", need_more_stb, exp_need);
        endtask

        task automatic report_test(input logic [8*24-1:0] name);
                test_count = test_count + 1;
                if (error_count == errors_before) begin
                        $display("test %0d %0s: ok", test_count, name);
                end else begin
                        $display("test %0d %0s: failed", test_count, name);
                end
        endtask

        initial begin
                test_count  = 0;
                error_count = 0;
                reset_done  = 1'b0;
                pend_reset  = 1'b0;
                pend_event  = 1'b0;
                checking    = 1'b0;
        end

        // the model follows each edge; results are compared half a cycle later.
        always @(posedge clk) begin
                if (rst) begin
                        model_credit = '0;
                        exp_change   = '0;
                        exp_vend     = 1'b0;
                        exp_need     = 1'b0;
                        pend_reset   = !reset_done;
                        pend_event   = 1'b0;
                        checking     = 1'b0;
                end else begin
                        exp_vend = 1'b0;
                        exp_need = 1'b0;
                        if (items != '0) begin
                                price_now = price_of(items);
                                if (model_credit >= price_now) begin
                                        exp_vend     = 1'b1;
                                        exp_change   = model_credit - price_now;
                                        model_credit = '0;
                                end else begin
                                        exp_need   = 1'b1;
                                        exp_change = '0; // a refused sale keeps the credit.
                                end
                        end else if (coins != '0 && model_credit < `VEND_CREDIT_CAP) begin
                                model_credit = model_credit + coin_value(coins);
                        end
                        pend_event = (items != '0) || (coins != '0);
                        ev_label   = label;
                        checking   = 1'b1;
                end
        end

        always @(negedge clk) begin
                if (pend_reset) begin
                        errors_before = error_count;
                        compare_all();
                        report_test("after reset");
                        reset_done = 1'b1;
                        pend_reset = 1'b0;
                end else if (checking) begin
                        errors_before = error_count;
                        compare_all(); // idle cycles are compared as well.
                        if (pend_event) begin
                                report_test(ev_label);
                        end
                        pend_event = 1'b0;
                end
        end

endmodule

`default_nettype wire

//--- sim/vend_assertions.sv
`timescale 1ns/10ps
`default_nettype none

`include "vend_cfg.svh"

module vend_assertions (
        input wire                            clk,
        input wire                            rst,
        input wire vend_panel_pkg::item_vec_t items,
        input wire vend_money_pkg::credit_t   credit,
        input wire                            vend_stb,
        input wire                            need_more_stb
);
        import vend_money_pkg::*;

        // 11 units just below the cap plus a 50-cent coin.
        localparam credit_t CREDIT_MAX = credit_t'(`VEND_CREDIT_CAP - 1 + `VEND_COIN_50);

        integer fail_count; // number of failed assertions so far.

        initial begin
                fail_count = 0;
        end

        strobes_exclusive: assert property (@(posedge clk) disable iff (rst)
                !(vend_stb && need_more_stb))
                else begin
                        $error("vend_stb and need_more_stb are high together");
                        fail_count = fail_count + 1;
                end

        // a strobe may only stay high when another selection arrives.
        strobe_single_cycle: assert property (@(posedge clk) disable iff (rst)
                (vend_stb || need_more_stb) && (items == '0) |=> !(vend_stb || need_more_stb))
                else begin
                        $error("result strobe held longer than one cycle");
                        fail_count = fail_count + 1;
                end

        credit_in_range: assert property (@(posedge clk) disable iff (rst)
                credit <= CREDIT_MAX)
                else begin
                        $error("credit 0x%h is above 0x%h", credit, CREDIT_MAX);
                        fail_count = fail_count + 1;
                end

endmodule

bind vend_machine vend_assertions u_vend_assertions (
        .clk           (clk),
        .rst           (rst),
        .items         (items),
        .credit        (credit),
        .vend_stb      (vend_stb),
        .need_more_stb (need_more_stb)
);

`default_nettype wire

//--- sim/tb_vend_machine.sv
`timescale 1ns/10ps
`default_nettype none

`include "vend_cfg.svh"

module tb_vend_machine;

        localparam integer TABLE_SIZE   = 40;
        localparam integer FILLER_COUNT = 8;
        localparam integer WAIT_LIMIT   = 20;

        logic                        clk;
        logic                        rst;
        logic [`VEND_COIN_BITS-1:0]  coins;
        logic [`VEND_ITEM_BITS-1:0]  items;
        logic [8*24-1:0]             label;
        wire  [`VEND_UNIT_BITS-1:0]  credit;
        wire  [`VEND_UNIT_BITS-1:0]  change;
        wire                         vend_stb;
        wire                         need_more_stb;
        integer                      test_count;
        integer                      error_count;

        logic [`VEND_COIN_BITS-1:0]  tbl_coins [0:TABLE_SIZE-1];
        logic [`VEND_ITEM_BITS-1:0]  tbl_items [0:TABLE_SIZE-1];
        logic [8*24-1:0]             tbl_label [0:TABLE_SIZE-1];
        integer                      entry_count;
        integer                      idx;
        integer                      seed;
        logic                        timed_out;

        vend_machine UUT (
                .clk           (clk),
                .rst           (rst),
                .coins         (coins),
                .items         (items),
                .credit        (credit),
                .change        (change),
                .vend_stb      (vend_stb),
                .need_more_stb (need_more_stb)
        );

        vend_checker u_checker (
                .clk           (clk),
                .rst           (rst),
                .coins         (coins),
                .items         (items),
                .label         (label),
                .credit        (credit),
                .change        (change),
                .vend_stb      (vend_stb),
                .need_more_stb (need_more_stb),
                .test_count    (test_count),
                .error_count   (error_count)
        );

        initial begin
                clk = 1'b0;
                forever #20 clk = ~clk;
        end

        task automatic add_entry(input logic [`VEND_COIN_BITS-1:0] c,
                                 input logic [`VEND_ITEM_BITS-1:0] i,
                                 input logic [8*24-1:0] name);
                tbl_coins[entry_count] = c;
                tbl_items[entry_count] = i;
                tbl_label[entry_count] = name;
                entry_count = entry_count + 1;
        endtask

        task automatic build_table;
                integer n;
                integer pick;
                logic [`VEND_COIN_BITS-1:0] c;
                entry_count = 0;
                add_entry(4'b0001, 5'b00000, "coin 5");
                add_entry(4'b0010, 5'b00000, "coin 10");
                add_entry(4'b0100, 5'b00000, "coin 20");
                add_entry(4'b1000, 5'b00000, "coin 50");
                add_entry(4'b0000, 5'b10000, "tub with 85 cents");
                add_entry(4'b0001, 5'b00000, "coin 5");
                add_entry(4'b0010, 5'b00000, "coin 10");
                add_entry(4'b0000, 5'b01000, "wrapper exact");
                add_entry(4'b1000, 5'b00000, "coin 50");
                add_entry(4'b0100, 5'b00000, "coin 20");
                add_entry(4'b0000, 5'b10000, "tub overpaid");
                add_entry(4'b0100, 5'b00000, "coin 20");
                add_entry(4'b0000, 5'b00010, "can short");
                add_entry(4'b0100, 5'b00000, "coin 20");
                add_entry(4'b0000, 5'b00010, "can after top-up");
                add_entry(4'b1000, 5'b00000, "coin 50");
                add_entry(4'b0010, 5'b00000, "coin 10 to cap");
                add_entry(4'b0001, 5'b00000, "coin 5 at cap");
                add_entry(4'b1000, 5'b00000, "coin 50 at cap");
                add_entry(4'b0000, 5'b10000, "tub at cap");
                add_entry(4'b1100, 5'b00000, "coins 1100");
                add_entry(4'b1111, 5'b00000, "coins 1111");
                add_entry(4'b0000, 5'b00101, "packet and bottle");
                add_entry(4'b0100, 5'b00000, "coin 20");
                add_entry(4'b0000, 5'b11111, "all items");
                add_entry(4'b1000, 5'b00001, "packet with coin 50");
                add_entry(4'b1000, 5'b00000, "coin 50");
                add_entry(4'b0100, 5'b00011, "packet and can with coin");
                for (n = 0; n < FILLER_COUNT; n = n + 1) begin
                        pick = $random(seed);
                        c = pick[`VEND_COIN_BITS-1:0];
                        if (c == '0) begin
                                c = 4'b0001; // an empty vector would be an idle cycle.
                        end
                        add_entry(c, 5'b00000, "random coin");
                end
                add_entry(4'b0000, 5'b10000, "tub after random coins");
        endtask

        task automatic wait_for_idle;
                integer waited;
                waited = 0;
                @(negedge clk);
                while ((credit !== '0 || change !== '0 || vend_stb !== 1'b0
                        || need_more_stb !== 1'b0) && waited < WAIT_LIMIT) begin
                        @(negedge clk);
                        waited = waited + 1;
                end
                if (credit !== '0 || change !== '0 || vend_stb !== 1'b0
                    || need_more_stb !== 1'b0) begin
                        $display("timeout: outputs did not settle after reset");
                        timed_out = 1'b1;
                end
        endtask

        // one cycle for the event and one idle cycle after it.
        task automatic apply_entry(input integer n);
                integer waited;
                coins = tbl_coins[n];
                items = tbl_items[n];
                label = tbl_label[n];
                @(negedge clk);
                coins = '0;
                items = '0;
                if (tbl_items[n] != '0) begin
                        waited = 0;
                        while (!(vend_stb || need_more_stb) && waited < WAIT_LIMIT) begin
                                @(negedge clk);
                                waited = waited + 1;
                        end
                        if (!(vend_stb || need_more_stb)) begin
                                $display("timeout: no result strobe for %0s", tbl_label[n]);
                                timed_out = 1'b1;
                        end
                end
                @(negedge clk);
        endtask

        initial begin
                seed      = 19;
                timed_out = 1'b0;
                rst       = 1'b1;
                coins     = '0;
                items     = '0;
                label     = '0;
                build_table();
                repeat (10) @(negedge clk);
                rst = 1'b0;
                wait_for_idle();
                idx = 0;
                while (idx < entry_count && !timed_out) begin
                        apply_entry(idx);
                        idx = idx + 1;
                end
                @(posedge clk); // the checker has finished its last compare by now.
                $display("%0d tests run, %0d errors, %0d assertion failures",
                         test_count, error_count, UUT.u_vend_assertions.fail_count);
                if (!timed_out && error_count == 0
                    && UUT.u_vend_assertions.fail_count == 0) begin
                        $display("Test passed");
                end else begin
                        $display("Test failed");
                end
                $finish;
        end

endmodule

`default_nettype wire

//--- vend_machine.f
+incdir+hdl
hdl/vend_money_pkg.sv
hdl/vend_panel_pkg.sv
hdl/vend_ifs.sv
hdl/panel_decoder.sv
hdl/credit_unit.sv
hdl/change_dispenser.sv
hdl/vend_machine.sv
sim/vend_checker.sv
sim/vend_assertions.sv
sim/tb_vend_machine.sv

//--- Bender.yml
package:
  name: vend_machine

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/vend_money_pkg.sv
      - hdl/vend_panel_pkg.sv
      - hdl/vend_ifs.sv
      - hdl/panel_decoder.sv
      - hdl/credit_unit.sv
      - hdl/change_dispenser.sv
      - hdl/vend_machine.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/vend_checker.sv
      - sim/vend_assertions.sv
      - sim/tb_vend_machine.sv
